// File: Bender.yml
package:
  name: mips_pipeline

sources:
  - hw/mips_pkg.sv
  - hw/fetch_stage.sv
  - hw/decode_stage.sv
  - hw/execute_stage.sv
  - hw/memory_stage.sv
  - hw/mips_pipeline.sv
  - target: simulation
    files:
      - sim/mips_pipeline_tb.sv

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                clk,
  input  logic                clr,
  input  mips_pkg::instr_t    d_inst,
  input  logic                wb_we,
  input  mips_pkg::reg_addr_t wb_dest,
  input  mips_pkg::word_t     wb_data,
  output logic                e_wreg,
  output logic                e_m2reg,
  output logic                e_wmem,
  output logic                e_aluimm,
  output mips_pkg::alu_op_t   e_aluc,
  output mips_pkg::reg_addr_t e_dest,
  output mips_pkg::word_t     e_qa,
  output mips_pkg::word_t     e_qb,
  output mips_pkg::word_t     e_imm
);

  logic                wreg;
  logic                m2reg;
  logic                wmem;
  logic                aluimm;
  mips_pkg::alu_op_t   aluc;
  mips_pkg::reg_addr_t dest;
  mips_pkg::word_t     imm32;
  mips_pkg::word_t     qa;
  mips_pkg::word_t     qb;
  mips_pkg::word_t     regs [32];

  //////////////////////////////
  // Control decode
  //////////////////////////////

  always_comb begin
    // Bubble unless the word is recognised
    wreg   = 1'b0;
    m2reg  = 1'b0;
    wmem   = 1'b0;
    aluimm = 1'b0;
    aluc   = mips_pkg::alu_add;
    dest   = '0;
    case (d_inst.r.op)
      mips_pkg::op_rtype: begin
        dest = d_inst.r.rd;
        wreg = 1'b1;
        case (d_inst.r.funct)
          mips_pkg::fn_add: aluc = mips_pkg::alu_add;
          mips_pkg::fn_sub: aluc = mips_pkg::alu_sub;
          mips_pkg::fn_and: aluc = mips_pkg::alu_and;
          mips_pkg::fn_or:  aluc = mips_pkg::alu_or;
          mips_pkg::fn_slt: aluc = mips_pkg::alu_slt;
          mips_pkg::fn_nor: aluc = mips_pkg::alu_nor;
          default: begin
            // Unknown function or the all-zero word
            wreg = 1'b0;
            dest = '0;
          end
        endcase
      end
      mips_pkg::op_lw: begin
        wreg   = 1'b1;
        m2reg  = 1'b1;
        aluimm = 1'b1;
        dest   = d_inst.i.rt;
      end
      mips_pkg::op_sw: begin
        wmem   = 1'b1;
        aluimm = 1'b1;
      end
      default: ;
    endcase
  end

  // Sign-extended offset
  assign imm32 = {{16{d_inst.i.imm[15]}}, d_inst.i.imm};

  //////////////////////////////
  // Register file
  //////////////////////////////

  // r0 reads as zero and a same-cycle write passes straight through
  function automatic mips_pkg::word_t rf_read(
    input mips_pkg::reg_addr_t addr,
    input mips_pkg::word_t     stored,
    input logic                we,
    input mips_pkg::reg_addr_t wd,
    input mips_pkg::word_t     wdata
  );
    if (addr == '0) begin
      return '0;
    end else if (we && wd == addr) begin
      return wdata;
    end
    return stored;
  endfunction

  assign qa = rf_read(d_inst.r.rs, regs[d_inst.r.rs], wb_we, wb_dest, wb_data);
  assign qb = rf_read(d_inst.r.rt, regs[d_inst.r.rt], wb_we, wb_dest, wb_data);

  always_ff @(posedge clk) begin
    if (wb_we && wb_dest != '0) begin
      regs[wb_dest] <= wb_data;
    end
  end

  //////////////////////////////
  // Decode/execute register
  //////////////////////////////

  always_ff @(posedge clk or negedge clr) begin
    if (!clr) begin
      e_wreg   <= 1'b0;
      e_m2reg  <= 1'b0;
      e_wmem   <= 1'b0;
      e_aluimm <= 1'b0;
      e_aluc   <= mips_pkg::alu_add;
      e_dest   <= '0;
    end else begin
      e_wreg   <= wreg;
      e_m2reg  <= m2reg;
      e_wmem   <= wmem;
      e_aluimm <= aluimm;
      e_aluc   <= aluc;
      e_dest   <= dest;
    end
  end

  // Operands
  always_ff @(posedge clk) begin
    e_qa  <= qa;
    e_qb  <= qb;
    e_imm <= imm32;
  end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                clk,
  input  logic                clr,
  input  logic                e_wreg,
  input  logic                e_m2reg,
  input  logic                e_wmem,
  input  logic                e_aluimm,
  input  mips_pkg::alu_op_t   e_aluc,
  input  mips_pkg::reg_addr_t e_dest,
  input  mips_pkg::word_t     e_qa,
  input  mips_pkg::word_t     e_qb,
  input  mips_pkg::word_t     e_imm,
  output logic                m_wreg,
  output logic                m_m2reg,
  output logic                m_wmem,
  output mips_pkg::reg_addr_t m_dest,
  output mips_pkg::word_t     m_result,
  output mips_pkg::word_t     m_qb
);

  mips_pkg::word_t opb;
  mips_pkg::word_t alu_out;

  // Second operand is the offset for lw and sw
  assign opb = e_aluimm ? e_imm : e_qb;

  //////////////////////////////
  // ALU
  //////////////////////////////

  always_comb begin
    case (e_aluc)
      mips_pkg::alu_and: alu_out = e_qa & opb;
      mips_pkg::alu_or:  alu_out = e_qa | opb;
      mips_pkg::alu_add: alu_out = e_qa + opb;
      mips_pkg::alu_sub: alu_out = e_qa - opb;
      // Signed compare
      mips_pkg::alu_slt: alu_out = ($signed(e_qa) < $signed(opb)) ? 32'd1 : 32'd0;
      mips_pkg::alu_nor: alu_out = ~(e_qa | opb);
      default:           alu_out = '0;
    endcase
  end

  //////////////////////////////
  // Execute/memory register
  //////////////////////////////

  always_ff @(posedge clk or negedge clr) begin
    if (!clr) begin
      m_wreg  <= 1'b0;
      m_m2reg <= 1'b0;
      m_wmem  <= 1'b0;
      m_dest  <= '0;
    end else begin
      m_wreg  <= e_wreg;
      m_m2reg <= e_m2reg;
      m_wmem  <= e_wmem;
      m_dest  <= e_dest;
    end
  end

  always_ff @(posedge clk) begin
    m_result <= alu_out;
    m_qb     <= e_qb;
  end

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
  input  logic                clk,
  input  logic                clr,
  input  logic                run,
  input  logic                load_we,
  input  logic                load_sel,
  input  mips_pkg::mem_addr_t load_addr,
  input  mips_pkg::word_t     load_data,
  output mips_pkg::word_t     pc,
  output mips_pkg::instr_t    d_inst
);

  mips_pkg::word_t     imem [mips_pkg::mem_depth];
  mips_pkg::mem_addr_t fetch_idx;
  mips_pkg::word_t     fetch_word;

  //////////////////////////////
  // Program counter
  //////////////////////////////

  // Holds while loading, steps one word per cycle while running
  always_ff @(posedge clk or negedge clr) begin
    if (!clr) begin
      pc <= '0;
    end else if (run) begin
      pc <= pc + 32'd4;
    end
  end

  //////////////////////////////
  // Instruction memory
  //////////////////////////////

  // Load port owns the memory only while the core is stopped
  always_ff @(posedge clk) begin
    if (!run && load_we && !load_sel) begin
      imem[load_addr] <= load_data;
    end
  end

  // Word address from pc bits 7 to 2
  assign fetch_idx  = pc[7:2];
  assign fetch_word = imem[fetch_idx];

  //////////////////////////////
  // Fetch/decode register
  //////////////////////////////

  // All zeros is a no-op, so a stopped core feeds bubbles
  always_ff @(posedge clk or negedge clr) begin
    if (!clr) begin
      d_inst <= '0;
    end else if (run) begin
      d_inst <= fetch_word;
    end else begin
      d_inst <= '0;
    end
  end

endmodule

// File: hw/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
  input  logic                clk,
  input  logic                clr,
  input  logic                run,
  input  logic                load_we,
  input  logic                load_sel,
  input  mips_pkg::mem_addr_t load_addr,
  input  mips_pkg::word_t     load_data,
  input  logic                m_wreg,
  input  logic                m_m2reg,
  input  logic                m_wmem,
  input  mips_pkg::reg_addr_t m_dest,
  input  mips_pkg::word_t     m_result,
  input  mips_pkg::word_t     m_qb,
  output logic                wb_we,
  output mips_pkg::reg_addr_t wb_dest,
  output mips_pkg::word_t     wb_data
);

  mips_pkg::word_t     dmem [mips_pkg::mem_depth];
  mips_pkg::mem_addr_t dmem_idx;
  mips_pkg::word_t     mem_word;

  //////////////////////////////
  // Data memory
  //////////////////////////////

  // Byte address from the ALU, word index from bits 7 to 2
  assign dmem_idx = m_result[7:2];
  assign mem_word = dmem[dmem_idx];

  // sw while running, load port while stopped
  always_ff @(posedge clk) begin
    if (run && m_wmem) begin
      dmem[dmem_idx] <= m_qb;
    end else if (!run && load_we && load_sel) begin
      dmem[load_addr] <= load_data;
    end
  end

  //////////////////////////////
  // Memory/write-back register
  //////////////////////////////

  always_ff @(posedge clk or negedge clr) begin
    if (!clr) begin
      wb_we   <= 1'b0;
      wb_dest <= '0;
    end else begin
      wb_we   <= m_wreg;
      wb_dest <= m_dest;
    end
  end

  // Loaded word for lw, ALU result otherwise
  always_ff @(posedge clk) begin
    wb_data <= m_m2reg ? mem_word : m_result;
  end

endmodule

// File: hw/mips_pipeline.sv
`timescale 1ns/1ps

module mips_pipeline (
  input  logic                clk,
  input  logic                clr,
  input  logic                run,
  input  logic                load_we,
  input  logic                load_sel,
  input  mips_pkg::mem_addr_t load_addr,
  input  mips_pkg::word_t     load_data,
  output mips_pkg::word_t     pc,
  output logic                wb_we,
  output mips_pkg::reg_addr_t wb_dest,
  output mips_pkg::word_t     wb_data
);

  // Fetch to decode
  mips_pkg::instr_t    d_inst;

  // Decode to execute
  logic                e_wreg;
  logic                e_m2reg;
  logic                e_wmem;
  logic                e_aluimm;
  mips_pkg::alu_op_t   e_aluc;
  mips_pkg::reg_addr_t e_dest;
  mips_pkg::word_t     e_qa;
  mips_pkg::word_t     e_qb;
  mips_pkg::word_t     e_imm;

  // Execute to memory
  logic                m_wreg;
  logic                m_m2reg;
  logic                m_wmem;
  mips_pkg::reg_addr_t m_dest;
  mips_pkg::word_t     m_result;
  mips_pkg::word_t     m_qb;

  fetch_stage fetch_stage_inst (
    .clk, .clr, .run, .load_we, .load_sel, .load_addr, .load_data,
    .pc, .d_inst
  );

  // Write-back triple loops back into the register file
  decode_stage decode_stage_inst (
    .clk, .clr, .d_inst, .wb_we, .wb_dest, .wb_data,
    .e_wreg, .e_m2reg, .e_wmem, .e_aluimm, .e_aluc, .e_dest, .e_qa, .e_qb, .e_imm
  );

  execute_stage execute_stage_inst (
    .clk, .clr,
    .e_wreg, .e_m2reg, .e_wmem, .e_aluimm, .e_aluc, .e_dest, .e_qa, .e_qb, .e_imm,
    .m_wreg, .m_m2reg, .m_wmem, .m_dest, .m_result, .m_qb
  );

  memory_stage memory_stage_inst (
    .clk, .clr, .run, .load_we, .load_sel, .load_addr, .load_data,
    .m_wreg, .m_m2reg, .m_wmem, .m_dest, .m_result, .m_qb,
    .wb_we, .wb_dest, .wb_data
  );

endmodule

// File: hw/mips_pkg.sv
package mips_pkg;

  //////////////////////////////
  // Basic widths
  //////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;

  // Word index into instruction or data memory
  typedef logic [5:0]  mem_addr_t;

  localparam int mem_depth = 64;

  //////////////////////////////
  // Opcodes and function fields
  //////////////////////////////

  localparam opcode_t op_rtype = 6'd0;
  localparam opcode_t op_lw    = 6'd35;
  localparam opcode_t op_sw    = 6'd43;

  localparam funct_t fn_add = 6'h20;
  localparam funct_t fn_sub = 6'h22;
  localparam funct_t fn_and = 6'h24;
  localparam funct_t fn_or  = 6'h25;
  localparam funct_t fn_nor = 6'h27;
  localparam funct_t fn_slt = 6'h2a;

  // ALU control codes
  localparam alu_op_t alu_and = 4'd0;
  localparam alu_op_t alu_or  = 4'd1;
  localparam alu_op_t alu_add = 4'd2;
  localparam alu_op_t alu_sub = 4'd6;
  localparam alu_op_t alu_slt = 4'd7;
  localparam alu_op_t alu_nor = 4'd12;

  // Instruction word seen as R format or I format
  typedef union packed {
    struct packed {
      opcode_t   op;
      reg_addr_t rs;
      reg_addr_t rt;
      reg_addr_t rd;
      logic [4:0] shamt;
      funct_t    funct;
    } r;
    struct packed {
      opcode_t     op;
      reg_addr_t   rs;
      reg_addr_t   rt;
      logic [15:0] imm;
    } i;
  } instr_t;

endpackage

// File: list.f
hw/mips_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/mips_pipeline.sv
sim/mips_pipeline_tb.sv

// File: sim/mips_pipeline_tb.sv
`timescale 1ns/1ps

module mips_pipeline_tb;

  logic                clk;
  logic                clr;
  logic                run;
  logic                load_we;
  logic                load_sel;
  mips_pkg::mem_addr_t load_addr;
  mips_pkg::word_t     load_data;
  mips_pkg::word_t     pc;
  logic                wb_we;
  mips_pkg::reg_addr_t wb_dest;
  mips_pkg::word_t     wb_data;

  // Expected write-backs in program order
  mips_pkg::reg_addr_t exp_dest [$];
  mips_pkg::word_t     exp_data [$];

  mips_pipeline mips_pipeline_inst (
    .clk, .clr, .run, .load_we, .load_sel, .load_addr, .load_data,
    .pc, .wb_we, .wb_dest, .wb_data
  );

  always #20 clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input mips_pkg::word_t expected,
                                 input mips_pkg::word_t actual);
    abort_run($sformatf("mismatch at %0t: %s expected %h, got %h",
                        $time, name, expected, actual));
  endtask

  // Outputs settle well before this point
  task automatic advance_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic check_pc(input mips_pkg::word_t expected);
    if (pc !== expected) report_mismatch("pc", expected, pc);
  endtask

  task automatic check_we(input logic expected);
    if (wb_we !== expected) report_mismatch("wb_we", 32'(expected), 32'(wb_we));
  endtask

  task automatic check_dest(input mips_pkg::reg_addr_t expected);
    if (wb_dest !== expected) report_mismatch("wb_dest", 32'(expected), 32'(wb_dest));
  endtask

  task automatic check_data(input mips_pkg::word_t expected);
    if (wb_data !== expected) report_mismatch("wb_data", expected, wb_data);
  endtask

  // One strobe on the load port
  task automatic load_word(input logic sel, input mips_pkg::mem_addr_t addr,
                           input mips_pkg::word_t data);
    load_we   = 1'b1;
    load_sel  = sel;
    load_addr = addr;
    load_data = data;
    advance_cycle();
    load_we   = 1'b0;
  endtask

  // I and D records go to the load port and E records are queued
  task automatic read_tests();
    int          fd;
    int          n;
    string       line;
    byte         kind;
    logic [31:0] addr;
    logic [31:0] value;
    fd = $fopen("sim/mips_tests.txt", "r");
    if (fd == 0) abort_run("cannot open sim/mips_tests.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%c %h %h", kind, addr, value);
      if (n != 3) abort_run($sformatf("malformed line in tests file: %s", line));
      case (kind)
        "I": load_word(1'b0, addr[5:0], value);
        "D": load_word(1'b1, addr[5:0], value);
        "E": begin
          exp_dest.push_back(addr[4:0]);
          exp_data.push_back(value);
        end
        default: abort_run($sformatf("unknown record kind in tests file: %s", line));
      endcase
    end
    $fclose(fd);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int cycles;
    clk       = 1'b0;
    clr       = 1'b0;
    run       = 1'b0;
    load_we   = 1'b0;
    load_sel  = 1'b0;
    load_addr = '0;
    load_data = '0;

    repeat (2) @(posedge clk);
    #5;
    clr = 1'b1;
    check_pc(32'd0);
    check_we(1'b0);

    read_tests();
    if (exp_dest.size() == 0) abort_run("tests file holds no expected write-backs");
    // Nothing moves while stopped
    check_pc(32'd0);
    check_we(1'b0);

    run = 1'b1;
    for (int i = 1; i <= 3; i++) begin
      advance_cycle();
      check_pc(32'(4 * i));
      check_we(1'b0);
    end

    // Each write-back in order with quiet no-op slots between
    while (exp_dest.size() > 0) begin
      cycles = 0;
      while (!wb_we) begin
        advance_cycle();
        cycles++;
        if (cycles == 16) begin
          abort_run($sformatf("no write-back arrived within 16 cycles, %0d still expected",
                              exp_dest.size()));
        end
      end
      check_dest(exp_dest.pop_front());
      check_data(exp_data.pop_front());
      advance_cycle();
    end

    // Tail of the program is empty
    repeat (3) begin
      check_we(1'b0);
      advance_cycle();
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: sim/mips_tests.txt
# I <imem word index> <instruction>, D <dmem word index> <data>, hex
# E <destination register> <write-back data>, hex, in program order
D 00 00000007
D 01 FFFFFFF6
D 02 12345678
D 03 0F0F00FF
I 00 8C010000
I 01 8C020004
I 02 8C030008
I 03 8C04000C
I 04 00222820
I 05 00223022
I 06 00643824
I 07 00644025
I 08 0041482A
I 09 0022502A
I 0A 00235827
I 0B AC050010
I 0C 00640020
I 0D 8C0C0010
I 0E 00000000
I 0F 00026820
E 01 00000007
E 02 FFFFFFF6
E 03 12345678
E 04 0F0F00FF
E 05 FFFFFFFD
E 06 00000011
E 07 02040078
E 08 1F3F56FF
E 09 00000001
E 0A 00000000
E 0B EDCBA980
E 00 21435777
E 0C FFFFFFFD
E 0D FFFFFFF6
